/* rp_analog_pkg.sv */
// fixed two-channel 14-bit datapath; widths are not meant to change, adc words carry 2 pad bits
package rp_analog_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int ADC_WORD_W = 16;  // raw word from the converter
  localparam int ADC_PAD_W  = 2;   // reserved low bits, dropped
  localparam int SAMPLE_W   = 14;  // signed sample
  localparam int SUM_W      = 15;  // gen + ctl, one guard bit

  ////////////////////////////////////////////////////////////
  // scalar types
  ////////////////////////////////////////////////////////////

  typedef logic [ADC_WORD_W-1:0] adc_word_t;      // as seen on the pins
  typedef logic signed [SAMPLE_W-1:0] sample_t;   // two's complement
  typedef logic [SAMPLE_W-1:0] dac_code_t;        // offset, negative slope

  ////////////////////////////////////////////////////////////
  // per-channel pairs and config / status
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    adc_word_t ch_a;
    adc_word_t ch_b;
  } adc_pair_t;

  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  typedef struct packed {
    dac_code_t ch_a;
    dac_code_t ch_b;
  } dac_pair_t;

  // limiter window, inclusive on both ends
  typedef struct packed {
    sample_t max_val;
    sample_t min_val;
  } limit_cfg_t;

  typedef struct packed {
    limit_cfg_t ch_a;
    limit_cfg_t ch_b;
  } limit_cfg_pair_t;

  typedef struct packed {
    logic upper;  // clamped at max_val
    logic lower;  // clamped at min_val
  } railed_t;

  typedef struct packed {
    railed_t ch_a;
    railed_t ch_b;
  } railed_pair_t;

endpackage

/* adc_frontend.sv */
`timescale 1ns/1ps
// two low adc bits are discarded; loopback mux is combinational, so lim_dat_i reaches adc_dat_o directly
module adc_frontend (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  input  rp_analog_pkg::adc_pair_t    adc_dat_i,       // raw converter words
  input  rp_analog_pkg::sample_pair_t lim_dat_i,       // limited dac sample
  input  logic                        digital_loop_i,  // 1 = feed dac back
  output rp_analog_pkg::sample_pair_t adc_dat_o        // to scope / controller
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////////////////////////
  // input registers
  ////////////////////////////////////////////////////////////

  dac_code_t raw_a_q;  // 14 kept bits, still converter code
  dac_code_t raw_b_q;
  sample_t   adc_a;    // decoded ch a
  sample_t   adc_b;

  // would sit in the io block on hardware
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      // code that decodes to zero
      raw_a_q <= {1'b0, {(SAMPLE_W-1){1'b1}}};
      raw_b_q <= {1'b0, {(SAMPLE_W-1){1'b1}}};
    end
    else
    begin
      raw_a_q <= adc_dat_i.ch_a[ADC_WORD_W-1:ADC_PAD_W];  // pad bits gone
      raw_b_q <= adc_dat_i.ch_b[ADC_WORD_W-1:ADC_PAD_W];
    end
  end

  ////////////////////////////////////////////////////////////
  // negative slope -> two's complement
  ////////////////////////////////////////////////////////////

  // msb kept, rest inverted
  assign adc_a = {raw_a_q[SAMPLE_W-1], ~raw_a_q[SAMPLE_W-2:0]};
  assign adc_b = {raw_b_q[SAMPLE_W-1], ~raw_b_q[SAMPLE_W-2:0]};

  // digital loopback
  // no register here, the dac sample is already a flop output
  assign adc_dat_o.ch_a = digital_loop_i ? lim_dat_i.ch_a : adc_a;
  assign adc_dat_o.ch_b = digital_loop_i ? lim_dat_i.ch_b : adc_b;

endmodule

/* output_limiter.sv */
`timescale 1ns/1ps
// limits are static levels and must satisfy min_val <= max_val; all outputs one cycle behind inputs
module output_limiter (
  input  logic                           adc_clk,
  input  logic                           rst_n_i,
  input  rp_analog_pkg::sample_pair_t    gen_dat_i,    // generator sample
  input  rp_analog_pkg::sample_pair_t    ctl_dat_i,    // controller sample
  input  rp_analog_pkg::limit_cfg_pair_t limit_cfg_i,  // per-channel window
  output rp_analog_pkg::sample_pair_t    lim_dat_o,    // limited sample
  output rp_analog_pkg::railed_pair_t    railed_o,     // clamp status
  output rp_analog_pkg::sample_pair_t    center_o      // middle of window
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////////////////////////
  // struct fields -> channel arrays, index 0 is ch a
  ////////////////////////////////////////////////////////////

  sample_t    gen_ch    [2];
  sample_t    ctl_ch    [2];
  limit_cfg_t cfg_ch    [2];
  sample_t    lim_ch    [2];
  railed_t    railed_ch [2];
  sample_t    center_ch [2];

  assign gen_ch[0] = gen_dat_i.ch_a;
  assign gen_ch[1] = gen_dat_i.ch_b;
  assign ctl_ch[0] = ctl_dat_i.ch_a;
  assign ctl_ch[1] = ctl_dat_i.ch_b;
  assign cfg_ch[0] = limit_cfg_i.ch_a;
  assign cfg_ch[1] = limit_cfg_i.ch_b;

  ////////////////////////////////////////////////////////////
  // per-channel sum, saturate, clamp
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++)
  begin : g_ch
    logic signed [SUM_W-1:0] sum;   // gen + ctl, sign extended
    logic signed [SUM_W-1:0] span;  // min + max, no overflow
    sample_t sat;                   // sum folded into 14 bits
    sample_t clamp;
    railed_t railed;
    sample_t lim_q;
    railed_t railed_q;
    sample_t center_q;

    assign sum  = gen_ch[i] + ctl_ch[i];
    assign span = cfg_ch[i].min_val + cfg_ch[i].max_val;

    // top two bits differ -> overflow, rail to the sign of the sum
    assign sat = (^sum[SUM_W-1:SUM_W-2]) ?
                 {sum[SUM_W-1], {(SAMPLE_W-1){~sum[SUM_W-1]}}} :
                 sum[SAMPLE_W-1:0];

    always_comb
    begin
      railed.upper = (sat > cfg_ch[i].max_val);  // above window
      railed.lower = (sat < cfg_ch[i].min_val);  // below window
      clamp        = sat;  // pass through by default
      if (railed.upper)
        clamp = cfg_ch[i].max_val;
      else if (railed.lower)
        clamp = cfg_ch[i].min_val;
    end

    always_ff @(posedge adc_clk or negedge rst_n_i)
    begin
      if (!rst_n_i)
      begin
        lim_q    <= '0;
        railed_q <= '0;
        center_q <= '0;
      end
      else
      begin
        lim_q    <= clamp;
        railed_q <= railed;
        center_q <= span[SUM_W-1:1];  // drop lsb = floor of half
      end
    end

    assign lim_ch[i]    = lim_q;
    assign railed_ch[i] = railed_q;
    assign center_ch[i] = center_q;

    // config sanity, an inverted window makes the clamp meaningless
    a_cfg_order : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      cfg_ch[i].min_val <= cfg_ch[i].max_val);

    // flags come from separate compares, exclusive only for a sane window
    a_railed_excl : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      !(railed_q.upper && railed_q.lower));
  end

  ////////////////////////////////////////////////////////////
  // back to pairs
  ////////////////////////////////////////////////////////////

  assign lim_dat_o.ch_a = lim_ch[0];
  assign lim_dat_o.ch_b = lim_ch[1];
  assign railed_o.ch_a  = railed_ch[0];
  assign railed_o.ch_b  = railed_ch[1];
  assign center_o.ch_a  = center_ch[0];
  assign center_o.ch_b  = center_ch[1];

endmodule

/* dac_encoder.sv */
`timescale 1ns/1ps
// both channels leave as parallel codes, no interleaving; resets to the mid-scale (zero) code
module dac_encoder (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  input  rp_analog_pkg::sample_pair_t lim_dat_i,  // signed, limited
  output rp_analog_pkg::dac_pair_t    dac_dat_o   // unsigned dac code
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////////////////////////
  // output register + signed -> offset, negative slope
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_o.ch_a <= {1'b0, {(SAMPLE_W-1){1'b1}}};  // encoding of 0
      dac_dat_o.ch_b <= {1'b0, {(SAMPLE_W-1){1'b1}}};
    end
    else
    begin
      // keep sign bit, invert magnitude bits
      dac_dat_o.ch_a <= {lim_dat_i.ch_a[SAMPLE_W-1], ~lim_dat_i.ch_a[SAMPLE_W-2:0]};
      dac_dat_o.ch_b <= {lim_dat_i.ch_b[SAMPLE_W-1], ~lim_dat_i.ch_b[SAMPLE_W-2:0]};
    end
  end

  // code is (mid-scale - 1) minus the sample, modulo 2^14
  // checked against the sample one cycle back
  a_dac_code : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |->
      (dac_dat_o.ch_a == dac_code_t'({1'b0, {(SAMPLE_W-1){1'b1}}} - $past(lim_dat_i.ch_a))) &&
      (dac_dat_o.ch_b == dac_code_t'({1'b0, {(SAMPLE_W-1){1'b1}}} - $past(lim_dat_i.ch_b))));

endmodule

/* analog_top.sv */
`timescale 1ns/1ps
// adc_clk domain only; gen/ctl to dac is 2 cycles, adc to adc_dat_o is 1, limits are static levels
module analog_top (
  input  logic                           adc_clk,
  input  logic                           rst_n_i,
  // converter side
  input  rp_analog_pkg::adc_pair_t       adc_dat_i,       // raw adc words
  output rp_analog_pkg::dac_pair_t       dac_dat_o,       // dac codes
  // sample sources
  input  rp_analog_pkg::sample_pair_t    gen_dat_i,       // generator
  input  rp_analog_pkg::sample_pair_t    ctl_dat_i,       // controller
  // static configuration
  input  rp_analog_pkg::limit_cfg_pair_t limit_cfg_i,
  input  logic                           digital_loop_i,
  // to scope / controller
  output rp_analog_pkg::sample_pair_t    adc_dat_o,
  output rp_analog_pkg::railed_pair_t    railed_o,        // for integrator reset
  output rp_analog_pkg::sample_pair_t    center_o         // middle of out range
);

  import rp_analog_pkg::*;

  sample_pair_t lim_dat;  // limiter out, feeds dac and loopback

  ////////////////////////////////////////////////////////////
  // adc input
  ////////////////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk       ),
    .rst_n_i        (rst_n_i       ),
    .adc_dat_i      (adc_dat_i     ),
    .lim_dat_i      (lim_dat       ),  // loopback source
    .digital_loop_i (digital_loop_i),
    .adc_dat_o      (adc_dat_o     )
  );

  ////////////////////////////////////////////////////////////
  // sum, saturation, limiting
  ////////////////////////////////////////////////////////////

  output_limiter u_output_limiter (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .gen_dat_i   (gen_dat_i  ),
    .ctl_dat_i   (ctl_dat_i  ),
    .limit_cfg_i (limit_cfg_i),
    .lim_dat_o   (lim_dat    ),
    .railed_o    (railed_o   ),
    .center_o    (center_o   )
  );

  ////////////////////////////////////////////////////////////
  // dac output
  ////////////////////////////////////////////////////////////

  dac_encoder u_dac_encoder (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .lim_dat_i (lim_dat  ),
    .dac_dat_o (dac_dat_o)
  );

endmodule

/* tb_analog_ref.svh */
// include after the tb's localparams and ch_expect_t; needs rng_state, errors and fail_run too
`ifndef TB_ANALOG_REF_SVH
`define TB_ANALOG_REF_SVH

////////////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////////////

// lcg, 32-bit state
function automatic logic [31:0] next_rand();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;
  return rng_state;
endfunction

function automatic sample_t random_sample();
  logic [31:0] r;
  r = next_rand();
  return sample_t'(r[31:18]);  // upper bits, better spread
endfunction

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

// negative slope around mid-scale: value = 8191 - code, mod 2^14
function automatic sample_t adc_decode(input adc_word_t word);
  dac_code_t kept;
  kept = word[ADC_WORD_W-1:ADC_PAD_W];  // pad bits ignored
  return sample_t'(dac_code_t'(SAMPLE_MAX) - kept);
endfunction

function automatic dac_code_t dac_encode(input sample_t s);
  return dac_code_t'(dac_code_t'(SAMPLE_MAX) - dac_code_t'(s));
endfunction

// full-range sum, then rail at the 14-bit limits
function automatic sample_t saturate(input sample_t gen, input sample_t ctl);
  int sum;
  sum = int'(gen) + int'(ctl);
  if (sum > SAMPLE_MAX)
    return sample_t'(SAMPLE_MAX);
  if (sum < SAMPLE_MIN)
    return sample_t'(SAMPLE_MIN);
  return sample_t'(sum);
endfunction

function automatic ch_expect_t channel_expect(input sample_t gen, input sample_t ctl,
                                              input limit_cfg_t cfg, input adc_word_t word);
  ch_expect_t e;
  sample_t    sat;
  sat      = saturate(gen, ctl);
  e.railed = '0;
  e.lim    = sat;
  if (sat > cfg.max_val)
  begin
    e.lim          = cfg.max_val;
    e.railed.upper = 1'b1;
  end
  else if (sat < cfg.min_val)
  begin
    e.lim          = cfg.min_val;
    e.railed.lower = 1'b1;
  end
  e.center = sample_t'((int'(cfg.min_val) + int'(cfg.max_val)) >>> 1);  // floor
  e.dec    = adc_decode(word);
  return e;
endfunction

// first mismatch ends the run
task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
  begin
    errors++;
    $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    fail_run();
  end
endtask

`endif

/* tb_analog_top.sv */
`timescale 1ns/1ps
// single clock; inputs move 1 ns after the rising edge, outputs are checked on the falling edge
module tb_analog_top;

  import rp_analog_pkg::*;

  localparam int SAMPLE_MAX   = 2**(SAMPLE_W-1) - 1;
  localparam int SAMPLE_MIN   = -(2**(SAMPLE_W-1));
  localparam int RESET_CYCLES = 10;
  localparam int PASS_LEN     = 200;  // adc decode, full-scale dac path
  localparam int OVF_LEN      = 200;  // forced rails every other cycle
  localparam int CLAMP_LEN    = 300;  // narrowed limits
  localparam int LOOP_LEN     = 200;  // digital loopback
  localparam int DRAIN_LEN    = 4;
  localparam int MAX_CYCLES   = RESET_CYCLES + PASS_LEN + OVF_LEN + CLAMP_LEN + LOOP_LEN
                                + DRAIN_LEN + 100;

  // expected per-channel results of one input cycle
  typedef struct packed {
    sample_t lim;
    railed_t railed;
    sample_t center;
    sample_t dec;
  } ch_expect_t;

  logic            adc_clk;
  logic            rst_n_i;
  adc_pair_t       adc_dat_i;
  sample_pair_t    gen_dat_i;
  sample_pair_t    ctl_dat_i;
  limit_cfg_pair_t limit_cfg_i;
  logic            digital_loop_i;
  sample_pair_t    adc_dat_o;
  dac_pair_t       dac_dat_o;
  railed_pair_t    railed_o;
  sample_pair_t    center_o;

  logic [31:0] rng_state = 32'h13e3_ecfb;
  int          errors    = 0;
  int          cycles    = 0;
  ch_expect_t  exp_q1 [2];  // one cycle back, index 0 is ch a
  ch_expect_t  exp_q2 [2];  // two cycles back

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped on the first error");
  endtask

  `include "tb_analog_ref.svh"

  analog_top u_dut (
    .adc_clk        (adc_clk       ),
    .rst_n_i        (rst_n_i       ),
    .adc_dat_i      (adc_dat_i     ),
    .dac_dat_o      (dac_dat_o     ),
    .gen_dat_i      (gen_dat_i     ),
    .ctl_dat_i      (ctl_dat_i     ),
    .limit_cfg_i    (limit_cfg_i   ),
    .digital_loop_i (digital_loop_i),
    .adc_dat_o      (adc_dat_o     ),
    .railed_o       (railed_o      ),
    .center_o       (center_o      )
  );

  initial adc_clk = 1'b0;
  always #20 adc_clk = ~adc_clk;  // 40 ns period

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // one clock, then new random inputs
  task automatic step(input bit force_ovf, input bit reload_limits);
    logic [31:0] r;
    sample_t     a;
    sample_t     b;
    @(posedge adc_clk);
    #1;
    r = next_rand();
    adc_dat_i.ch_a = r[31:16];
    r = next_rand();
    adc_dat_i.ch_b = r[31:16];
    gen_dat_i.ch_a = random_sample();
    gen_dat_i.ch_b = random_sample();
    ctl_dat_i.ch_a = random_sample();
    ctl_dat_i.ch_b = random_sample();
    if (force_ovf)
    begin
      r = next_rand();
      gen_dat_i.ch_a = r[31] ? sample_t'(SAMPLE_MAX) : sample_t'(SAMPLE_MIN);
      ctl_dat_i.ch_a = gen_dat_i.ch_a;  // same rail twice, always overflows
      gen_dat_i.ch_b = r[31] ? sample_t'(SAMPLE_MIN) : sample_t'(SAMPLE_MAX);
      ctl_dat_i.ch_b = gen_dat_i.ch_b;
    end
    if (reload_limits)
    begin
      a = random_sample();
      b = random_sample();
      limit_cfg_i.ch_a.max_val = (a > b) ? a : b;  // keep min <= max
      limit_cfg_i.ch_a.min_val = (a > b) ? b : a;
      a = random_sample();
      b = random_sample();
      limit_cfg_i.ch_b.max_val = (a > b) ? a : b;
      limit_cfg_i.ch_b.min_val = (a > b) ? b : a;
    end
  endtask

  initial
  begin
    rst_n_i        = 1'b0;
    adc_dat_i      = '0;
    gen_dat_i      = '0;
    ctl_dat_i      = '0;
    digital_loop_i = 1'b0;
    limit_cfg_i.ch_a.max_val = sample_t'(SAMPLE_MAX);  // full scale
    limit_cfg_i.ch_a.min_val = sample_t'(SAMPLE_MIN);
    limit_cfg_i.ch_b         = limit_cfg_i.ch_a;
    foreach (exp_q1[i])
    begin
      exp_q1[i] = '0;  // reset state of every register
      exp_q2[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge adc_clk);
    #1 rst_n_i = 1'b1;

    repeat (PASS_LEN) step(1'b0, 1'b0);
    for (int i = 0; i < OVF_LEN; i++)
      step(i[0], 1'b0);
    for (int i = 0; i < CLAMP_LEN; i++)
      step(1'b0, (i % 20) == 0);  // new window every 20 cycles
    digital_loop_i = 1'b1;        // adc words ignored from here on
    repeat (LOOP_LEN) step(1'b0, 1'b0);
    repeat (DRAIN_LEN) @(posedge adc_clk);
    @(negedge adc_clk);

    if (errors == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
      fail_run();
  end

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic compare_outputs();
    check_equal("dac ch a", dac_dat_o.ch_a, dac_encode(exp_q2[0].lim));  // 2 cycles
    check_equal("dac ch b", dac_dat_o.ch_b, dac_encode(exp_q2[1].lim));
    check_equal("railed ch a", railed_o.ch_a, exp_q1[0].railed);
    check_equal("railed ch b", railed_o.ch_b, exp_q1[1].railed);
    check_equal("center ch a", center_o.ch_a, exp_q1[0].center);
    check_equal("center ch b", center_o.ch_b, exp_q1[1].center);
    // loopback mux is combinational
    check_equal("adc ch a", adc_dat_o.ch_a, digital_loop_i ? exp_q1[0].lim : exp_q1[0].dec);
    check_equal("adc ch b", adc_dat_o.ch_b, digital_loop_i ? exp_q1[1].lim : exp_q1[1].dec);
  endtask

  always @(negedge adc_clk)
  begin
    if (rst_n_i)
    begin
      compare_outputs();
      exp_q2    = exp_q1;  // shift history
      exp_q1[0] = channel_expect(gen_dat_i.ch_a, ctl_dat_i.ch_a, limit_cfg_i.ch_a,
                                 adc_dat_i.ch_a);
      exp_q1[1] = channel_expect(gen_dat_i.ch_b, ctl_dat_i.ch_b, limit_cfg_i.ch_b,
                                 adc_dat_i.ch_b);
    end
  end

  // hang guard
  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("Timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
      fail_run();
    end
  end

endmodule

/* tb.f */
+incdir+.
rp_analog_pkg.sv
adc_frontend.sv
output_limiter.sv
dac_encoder.sv
analog_top.sv
tb_analog_top.sv
